//--- rtl/dma_pkg.sv
package dma_pkg;

	// Burst geometry
	localparam int BURST_LEN = 32;
	localparam int BURST_BYTES = 4 * BURST_LEN;

	// Buffer sizing, count reaches BUF_DEPTH
	localparam int BUF_DEPTH = 128;
	localparam int COUNT_W = 8;

	// DDR user port byte address
	localparam int ADDR_W = 30;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_WR_FETCH,
		ST_WR_WAIT,
		ST_WR_NEXT,
		ST_RD_CMD,
		ST_RD_WAIT,
		ST_RD_TAKE,
		ST_RD_NEXT
	} dma_state_t;

	// Command codes of the DDR user port
	typedef enum logic [2:0] {
		MEM_WRITE = 3'b000,
		MEM_READ = 3'b001
	} mem_instr_t;

endpackage

//--- rtl/word_fifo.sv
`timescale 1ns/1ns

module word_fifo
	import dma_pkg::*;
(
	input logic clk,
	input logic reset_d,
	input logic push,
	input logic pop,
	input logic [31:0] push_data,
	output logic [31:0] pop_data,
	output logic pop_valid,
	output logic empty,
	output logic full,
	output logic [COUNT_W-1:0] count
);

	logic [31:0] mem [BUF_DEPTH];
	logic [$clog2(BUF_DEPTH)-1:0] wr_ptr;
	logic [$clog2(BUF_DEPTH)-1:0] rd_ptr;
	logic push_ok;
	logic pop_ok;

	assign empty = (count == '0);
	assign full = (count == COUNT_W'(BUF_DEPTH));

	// Overrun and underrun attempts are dropped
	assign push_ok = push && !full;
	assign pop_ok = pop && !empty;

	// Pointers wrap by themselves, depth is a power of two
	always_ff @(posedge clk or posedge reset_d) begin
		if (reset_d) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push_ok) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop_ok) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	// Occupancy, unchanged when push and pop coincide
	always_ff @(posedge clk or posedge reset_d) begin
		if (reset_d) begin
			count <= '0;
		end else if (push_ok && !pop_ok) begin
			count <= count + 1'b1;
		end else if (pop_ok && !push_ok) begin
			count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk or posedge reset_d) begin
		if (reset_d) begin
			pop_valid <= 1'b0;
		end else begin
			pop_valid <= pop_ok;
		end
	end

	// Storage and registered read port
	always_ff @(posedge clk) begin
		if (push_ok) begin
			mem[wr_ptr] <= push_data;
		end
		if (pop_ok) begin
			pop_data <= mem[rd_ptr];
		end
	end

endmodule

//--- rtl/dma_engine.sv
`timescale 1ns/1ns

module dma_engine
	import dma_pkg::*;
(
	input logic clk,
	input logic reset_d,
	input logic writes_en,
	input logic reads_en,
	input logic calib_done,
	input logic [ADDR_W-1:0] start_addr,
	// Input buffer side
	output logic ib_re,
	input logic [31:0] ib_data,
	input logic ib_valid,
	input logic [COUNT_W-1:0] ib_count,
	// Output buffer side
	output logic ob_we,
	output logic [31:0] ob_data,
	input logic [COUNT_W-1:0] ob_count,
	// DDR command path
	input logic cmd_full,
	output logic cmd_en,
	output mem_instr_t cmd_instr,
	output logic [ADDR_W-1:0] cmd_byte_addr,
	output logic [5:0] cmd_bl,
	// DDR write data path
	input logic wr_full,
	output logic wr_en,
	output logic [31:0] wr_data,
	output logic [3:0] wr_mask,
	// DDR read data path
	output logic rd_en,
	input logic rd_empty,
	input logic [31:0] rd_data
);

	dma_state_t state;
	dma_state_t state_nxt;
	logic write_mode;
	logic read_mode;
	logic [5:0] burst_cnt;
	logic burst_done;
	logic [ADDR_W-1:0] wr_addr;
	logic [ADDR_W-1:0] rd_addr;
	logic [31:0] word_hold;
	logic have_word;
	logic wr_start;
	logic rd_start;

	assign cmd_bl = 6'(BURST_LEN - 1);
	assign wr_mask = 4'b0000;

	assign burst_done = (burst_cnt == '0);

	// Start conditions keep both buffers from overrunning
	assign wr_start = calib_done && write_mode && (ib_count >= COUNT_W'(BURST_LEN));
	assign rd_start = calib_done && read_mode
		&& (ob_count <= COUNT_W'(BUF_DEPTH - 1 - BURST_LEN));

	assign ib_re = (state == ST_WR_FETCH);

	// A word that met wr_full waits in word_hold
	assign wr_en = (state == ST_WR_WAIT) && (ib_valid || have_word) && !wr_full;
	assign wr_data = have_word ? word_hold : ib_data;

	assign rd_en = (state == ST_RD_WAIT) && !rd_empty;

	// Write command goes out only after the last data word
	assign cmd_en = !cmd_full
		&& (((state == ST_WR_NEXT) && burst_done) || (state == ST_RD_CMD));
	assign cmd_instr = (state == ST_RD_CMD) ? MEM_READ : MEM_WRITE;
	assign cmd_byte_addr = (state == ST_RD_CMD) ? rd_addr : wr_addr;

	always_comb begin
		state_nxt = state;
		case (state)
			// Write wins when both could start
			ST_IDLE: begin
				if (wr_start) begin
					state_nxt = ST_WR_FETCH;
				end else if (rd_start) begin
					state_nxt = ST_RD_CMD;
				end
			end
			ST_WR_FETCH: state_nxt = ST_WR_WAIT;
			ST_WR_WAIT: begin
				if (wr_en) begin
					state_nxt = ST_WR_NEXT;
				end
			end
			ST_WR_NEXT: begin
				if (!burst_done) begin
					state_nxt = ST_WR_FETCH;
				end else if (cmd_en) begin
					state_nxt = ST_IDLE;
				end
			end
			ST_RD_CMD: begin
				if (cmd_en) begin
					state_nxt = ST_RD_WAIT;
				end
			end
			ST_RD_WAIT: begin
				if (rd_en) begin
					state_nxt = ST_RD_TAKE;
				end
			end
			ST_RD_TAKE: state_nxt = ST_RD_NEXT;
			ST_RD_NEXT: state_nxt = burst_done ? ST_IDLE : ST_RD_WAIT;
			default: state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk or posedge reset_d) begin
		if (reset_d) begin
			state <= ST_IDLE;
			write_mode <= 1'b0;
			read_mode <= 1'b0;
			burst_cnt <= '0;
			have_word <= 1'b0;
			ob_we <= 1'b0;
			wr_addr <= start_addr;
			rd_addr <= start_addr;
		end else begin
			state <= state_nxt;
			write_mode <= writes_en;
			read_mode <= reads_en;
			ob_we <= (state == ST_RD_TAKE);

			// Words left in the current burst
			if (state == ST_IDLE) begin
				burst_cnt <= 6'(BURST_LEN);
			end else if (wr_en || (state == ST_RD_TAKE)) begin
				burst_cnt <= burst_cnt - 6'd1;
			end

			if (ib_valid && wr_full) begin
				have_word <= 1'b1;
			end else if (wr_en) begin
				have_word <= 1'b0;
			end

			// Each kind of command steps its own address
			if (cmd_en && (state == ST_WR_NEXT)) begin
				wr_addr <= wr_addr + ADDR_W'(BURST_BYTES);
			end
			if (cmd_en && (state == ST_RD_CMD)) begin
				rd_addr <= rd_addr + ADDR_W'(BURST_BYTES);
			end
		end
	end

	// Data registers
	always_ff @(posedge clk) begin
		if (ib_valid) begin
			word_hold <= ib_data;
		end
		if (state == ST_RD_TAKE) begin
			ob_data <= rd_data;
		end
	end

endmodule

//--- rtl/dma_top.sv
`timescale 1ns/1ns

module dma_top
	import dma_pkg::*;
(
	input logic clk,
	input logic reset_d,
	input logic writes_en,
	input logic reads_en,
	input logic calib_done,
	input logic [ADDR_W-1:0] start_addr,
	// Stream source
	input logic in_we,
	input logic [31:0] in_data,
	output logic in_full,
	// Stream consumer
	input logic out_re,
	output logic [31:0] out_data,
	output logic out_valid,
	output logic out_empty,
	// DDR user port
	input logic cmd_full,
	output logic cmd_en,
	output mem_instr_t cmd_instr,
	output logic [ADDR_W-1:0] cmd_byte_addr,
	output logic [5:0] cmd_bl,
	input logic wr_full,
	output logic wr_en,
	output logic [31:0] wr_data,
	output logic [3:0] wr_mask,
	output logic rd_en,
	input logic rd_empty,
	input logic [31:0] rd_data
);

	logic ib_re;
	logic [31:0] ib_data;
	logic ib_valid;
	logic [COUNT_W-1:0] ib_count;
	logic ob_we;
	logic [31:0] ob_data;
	logic [COUNT_W-1:0] ob_count;

	// Stream words waiting for a write burst
	word_fifo u_in_buf (
		.clk(clk),
		.reset_d(reset_d),
		.push(in_we),
		.pop(ib_re),
		.push_data(in_data),
		.pop_data(ib_data),
		.pop_valid(ib_valid),
		.empty(),
		.full(in_full),
		.count(ib_count)
	);

	dma_engine u_engine (
		.clk(clk),
		.reset_d(reset_d),
		.writes_en(writes_en),
		.reads_en(reads_en),
		.calib_done(calib_done),
		.start_addr(start_addr),
		.ib_re(ib_re),
		.ib_data(ib_data),
		.ib_valid(ib_valid),
		.ib_count(ib_count),
		.ob_we(ob_we),
		.ob_data(ob_data),
		.ob_count(ob_count),
		.cmd_full(cmd_full),
		.cmd_en(cmd_en),
		.cmd_instr(cmd_instr),
		.cmd_byte_addr(cmd_byte_addr),
		.cmd_bl(cmd_bl),
		.wr_full(wr_full),
		.wr_en(wr_en),
		.wr_data(wr_data),
		.wr_mask(wr_mask),
		.rd_en(rd_en),
		.rd_empty(rd_empty),
		.rd_data(rd_data)
	);

	// Read-back words for the consumer
	word_fifo u_out_buf (
		.clk(clk),
		.reset_d(reset_d),
		.push(ob_we),
		.pop(out_re),
		.push_data(ob_data),
		.pop_data(out_data),
		.pop_valid(out_valid),
		.empty(out_empty),
		.full(),
		.count(ob_count)
	);

endmodule

//--- testbench/dma_sva.sv
`timescale 1ns/1ns

module dma_sva
	import dma_pkg::*;
(
	input logic clk,
	input logic reset_d,
	input logic calib_done,
	input logic cmd_en,
	input logic cmd_full,
	input logic wr_en,
	input logic wr_full,
	input logic rd_en,
	input logic [COUNT_W-1:0] ob_count
);

	int fail_count = 0;

	// No DDR traffic until the controller is calibrated
	no_traffic_before_calib: assert property (@(posedge clk) disable iff (reset_d)
		!calib_done |-> !(cmd_en || wr_en || rd_en))
	else begin
		$error("DDR strobe before calibration");
		fail_count++;
	end

	cmd_held_while_full: assert property (@(posedge clk) disable iff (reset_d)
		cmd_full |-> !cmd_en)
	else begin
		$error("cmd_en while cmd_full");
		fail_count++;
	end

	wr_held_while_full: assert property (@(posedge clk) disable iff (reset_d)
		wr_full |-> !wr_en)
	else begin
		$error("wr_en while wr_full");
		fail_count++;
	end

	no_read_into_full_buffer: assert property (@(posedge clk) disable iff (reset_d)
		rd_en |-> (ob_count != COUNT_W'(BUF_DEPTH)))
	else begin
		$error("rd_en with the output buffer full");
		fail_count++;
	end

	cmd_single_cycle: assert property (@(posedge clk) disable iff (reset_d)
		cmd_en |=> !cmd_en)
	else begin
		$error("cmd_en longer than one cycle");
		fail_count++;
	end

endmodule

bind dma_engine dma_sva u_sva (.*);

//--- testbench/ddr_port_model.sv
`timescale 1ns/1ns

module ddr_port_model
	import dma_pkg::*;
(
	input logic clk,
	input logic reset_d,
	input logic cmd_en,
	input mem_instr_t cmd_instr,
	input logic [ADDR_W-1:0] cmd_byte_addr,
	input logic [5:0] cmd_bl,
	output logic cmd_full,
	input logic wr_en,
	input logic [31:0] wr_data,
	input logic [3:0] wr_mask,
	output logic wr_full,
	input logic rd_en,
	output logic rd_empty,
	output logic [31:0] rd_data
);

	// Word addressed, enough for a few bursts
	logic [31:0] mem [1024];
	logic [31:0] wr_q [$];
	logic [31:0] rd_q [$];
	logic [31:0] rd_word;
	logic [9:0] base;
	int rd_delay;

	// Strobes are taken at the rising edge
	always @(posedge clk or posedge reset_d) begin
		if (reset_d) begin
			wr_q.delete();
			rd_q.delete();
			rd_delay = 0;
		end else begin
			if (wr_en) begin
				wr_q.push_back(wr_data);
			end
			if (rd_en && rd_q.size() != 0) begin
				rd_word = rd_q.pop_front();
			end
			if (rd_delay > 0) begin
				rd_delay--;
			end
			if (cmd_en) begin
				base = cmd_byte_addr[11:2];
				for (int i = 0; i < BURST_LEN; i++) begin
					if (cmd_instr == MEM_WRITE && wr_q.size() != 0) begin
						mem[base + 10'(i)] = wr_q.pop_front();
					end else if (cmd_instr == MEM_READ) begin
						rd_q.push_back(mem[base + 10'(i)]);
					end
				end
				// Read data shows up after a random latency
				if (cmd_instr == MEM_READ) begin
					rd_delay = $urandom_range(10, 2);
				end
			end
		end
	end

	// Outputs change on the falling edge
	initial begin
		cmd_full = 1'b0;
		wr_full = 1'b0;
		rd_empty = 1'b1;
		rd_data = '0;
		forever begin
			@(negedge clk);
			// Back-pressure on about one cycle in four
			cmd_full = ($urandom_range(3) == 0);
			wr_full = ($urandom_range(3) == 0);
			rd_empty = (rd_q.size() == 0) || (rd_delay != 0);
			rd_data = rd_word;
		end
	end

endmodule

//--- testbench/dma_tb.sv
`timescale 1ns/1ns

module dma_tb
	import dma_pkg::*;
();

	localparam int NUM_BURSTS = 4;
	localparam int TOTAL_WORDS = NUM_BURSTS * BURST_LEN;
	// Eight bursts at about 3 cycles per word plus random stalls
	localparam int MAX_CYCLES = 4000;
	localparam logic [ADDR_W-1:0] START_ADDR = 30'h0000_1000;

	logic clk;
	logic reset_d;
	logic writes_en;
	logic reads_en;
	logic calib_done;
	logic [ADDR_W-1:0] start_addr;
	logic in_we;
	logic [31:0] in_data;
	logic in_full;
	logic out_re;
	logic [31:0] out_data;
	logic out_valid;
	logic out_empty;
	logic cmd_full;
	logic cmd_en;
	mem_instr_t cmd_instr;
	logic [ADDR_W-1:0] cmd_byte_addr;
	logic [5:0] cmd_bl;
	logic wr_full;
	logic wr_en;
	logic [31:0] wr_data;
	logic [3:0] wr_mask;
	logic rd_en;
	logic rd_empty;
	logic [31:0] rd_data;

	logic [31:0] wr_expect [$];
	logic [31:0] rd_expect [$];
	int errors = 0;
	int wr_cmds = 0;
	int rd_cmds = 0;
	int burst_words = 0;
	int words_out = 0;
	int cycles;

	dma_top DUT (
		.clk(clk), .reset_d(reset_d), .writes_en(writes_en), .reads_en(reads_en),
		.calib_done(calib_done), .start_addr(start_addr),
		.in_we(in_we), .in_data(in_data), .in_full(in_full),
		.out_re(out_re), .out_data(out_data), .out_valid(out_valid), .out_empty(out_empty),
		.cmd_full(cmd_full), .cmd_en(cmd_en), .cmd_instr(cmd_instr),
		.cmd_byte_addr(cmd_byte_addr), .cmd_bl(cmd_bl),
		.wr_full(wr_full), .wr_en(wr_en), .wr_data(wr_data), .wr_mask(wr_mask),
		.rd_en(rd_en), .rd_empty(rd_empty), .rd_data(rd_data)
	);

	ddr_port_model u_mem (
		.clk(clk), .reset_d(reset_d),
		.cmd_en(cmd_en), .cmd_instr(cmd_instr), .cmd_byte_addr(cmd_byte_addr),
		.cmd_bl(cmd_bl), .cmd_full(cmd_full),
		.wr_en(wr_en), .wr_data(wr_data), .wr_mask(wr_mask), .wr_full(wr_full),
		.rd_en(rd_en), .rd_empty(rd_empty), .rd_data(rd_data)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic report_mismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("ERROR at %0t: %s expected %h, got %h", $time, name, expected, actual);
		errors++;
	endtask

	task automatic report_failure(input string what);
		$display("At %0t: %s", $time, what);
	endtask

	task automatic check_write_word();
		logic [31:0] expected;
		if (wr_expect.size() == 0) begin
			report_failure("write strobe with no input word left to match");
			errors++;
		end else begin
			expected = wr_expect.pop_front();
			assert (wr_data == expected) else report_mismatch("wr_data", expected, wr_data);
		end
		assert (wr_mask == 4'b0000) else report_mismatch("wr_mask", 32'h0, 32'(wr_mask));
		burst_words++;
	endtask

	// Each kind of command walks up from start_addr in burst steps
	task automatic check_command();
		logic [ADDR_W-1:0] expected;
		assert (cmd_bl == 6'(BURST_LEN - 1)) else report_mismatch("cmd_bl", BURST_LEN - 1,
			32'(cmd_bl));
		if (cmd_instr == MEM_WRITE) begin
			expected = START_ADDR + ADDR_W'(wr_cmds * BURST_BYTES);
			assert (burst_words == BURST_LEN) else report_mismatch("wr_en count", BURST_LEN,
				burst_words);
			wr_cmds++;
			burst_words = 0;
		end else begin
			expected = START_ADDR + ADDR_W'(rd_cmds * BURST_BYTES);
			rd_cmds++;
		end
		assert (cmd_byte_addr == expected)
			else report_mismatch("cmd_byte_addr", 32'(expected), 32'(cmd_byte_addr));
	endtask

	task automatic check_read_word();
		logic [31:0] expected;
		if (rd_expect.size() == 0) begin
			report_failure("output word with nothing left to expect");
			errors++;
		end else begin
			expected = rd_expect.pop_front();
			assert (out_data == expected) else report_mismatch("out_data", expected, out_data);
		end
		words_out++;
	endtask

	// Scoreboard sampled at the rising edge
	always @(posedge clk) begin
		if (!reset_d) begin
			if (in_we && !in_full) begin
				wr_expect.push_back(in_data);
				rd_expect.push_back(in_data);
			end
			if (wr_en) begin
				check_write_word();
			end
			if (cmd_en) begin
				check_command();
			end
			if (out_valid) begin
				check_read_word();
			end
		end
	end

	task automatic push_words(input int n);
		int sent;
		sent = 0;
		while (sent < n) begin
			@(negedge clk);
			in_we = !in_full;
			in_data = $urandom;
			if (!in_full) begin
				sent++;
			end
		end
		@(negedge clk);
		in_we = 1'b0;
	endtask

	initial begin
		int end_errors;
		int total;
		end_errors = 0;
		void'($urandom(28));
		reset_d = 1'b1;
		writes_en = 1'b0;
		reads_en = 1'b0;
		calib_done = 1'b0;
		start_addr = START_ADDR;
		in_we = 1'b0;
		in_data = '0;
		out_re = 1'b0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset_d = 1'b0;

		// Full input buffer while calibration is still pending
		writes_en = 1'b1;
		reads_en = 1'b1;
		push_words(TOTAL_WORDS);
		repeat (20) @(negedge clk);
		assert (in_full) else report_mismatch("in_full", 32'h1, 32'(in_full));
		calib_done = 1'b1;
		wait (wr_cmds == NUM_BURSTS);
		@(negedge clk);
		writes_en = 1'b0;

		// Consumer idle until the output buffer blocks the next burst
		wait (rd_cmds == NUM_BURSTS - 1 && DUT.ob_count == COUNT_W'(3 * BURST_LEN));
		repeat (40) @(negedge clk);
		assert (rd_cmds == NUM_BURSTS - 1) else begin
			report_failure("read burst started while the output buffer had no room");
			end_errors++;
		end

		while (words_out < TOTAL_WORDS) begin
			@(negedge clk);
			out_re = !out_empty;
			if (rd_cmds == NUM_BURSTS) begin
				reads_en = 1'b0;
			end
		end
		out_re = 1'b0;
		repeat (5) @(negedge clk);
		assert (out_empty) else report_mismatch("out_empty", 32'h1, 32'(out_empty));
		assert (wr_expect.size() == 0 && rd_expect.size() == 0) else begin
			report_failure("words left over in the scoreboard");
			end_errors++;
		end

		total = errors + end_errors + DUT.u_engine.u_sva.fail_count;
		$display("Done: %0d data errors, %0d end errors, %0d assertion failures",
			errors, end_errors, DUT.u_engine.u_sva.fail_count);
		if (total == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

	initial begin
		cycles = 0;
		while (cycles < MAX_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: DMA not finished after %0d cycles, %0d data errors so far",
			MAX_CYCLES, errors);
		$display("Test FAILED");
		$finish;
	end

endmodule

//--- dma_buffer.f
rtl/dma_pkg.sv
rtl/word_fifo.sv
rtl/dma_engine.sv
rtl/dma_top.sv
testbench/dma_sva.sv
testbench/ddr_port_model.sv
testbench/dma_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= dma_tb
FILELIST ?= dma_buffer.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
SIM_ARGS ?= +verilator+error+limit+100
PASS_MSG ?= Test OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
